/* Makefile */
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -j 0
TOP       := tb_ghash
FILE_LIST := tb.f
OBJ_DIR   := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)

# A $fatal in the testbench gives a non-zero exit status.
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* common/ghash_pkg.sv */
// GHASH accelerator shared widths, register map, control bits and block types.
package ghash_pkg;

    // Field element and block width.
    localparam int NB_DATA = 128;

    // AXI4-Lite bus widths.
    localparam int NB_AXI_DATA = 32;
    localparam int NB_AXI_ADDR = 8;
    localparam int NB_AXI_STRB = NB_AXI_DATA / 8;
    localparam int NB_BYTE = 8;
    localparam int NB_RESP = 2;

    // Absorbed-block counter width.
    localparam int NB_COUNT = 16;

    // Register words per 128-bit block.
    localparam int NB_WORDS = NB_DATA / NB_AXI_DATA;

    // Reduction constant for x^128 + x^7 + x^2 + x + 1, GCM bit order.
    localparam logic [NB_DATA-1:0] GF_R = {8'hE1, {(NB_DATA - 8){1'b0}}};

    // Register map. Word 0 of each block is bits 127:96.
    localparam logic [NB_AXI_ADDR-1:0] ADDR_H0 = 8'h00;
    localparam logic [NB_AXI_ADDR-1:0] ADDR_X0 = 8'h10;
    localparam logic [NB_AXI_ADDR-1:0] ADDR_CTRL = 8'h20;
    localparam logic [NB_AXI_ADDR-1:0] ADDR_Y0 = 8'h30;
    localparam logic [NB_AXI_ADDR-1:0] ADDR_COUNT = 8'h40;

    // Control register bits, self-clearing.
    localparam int CTRL_ABSORB = 0;
    localparam int CTRL_CLEAR = 1;

    // AXI response codes.
    localparam logic [NB_RESP-1:0] RESP_OKAY = 2'b00;
    localparam logic [NB_RESP-1:0] RESP_SLVERR = 2'b10;

    // One block, seen whole or as four bus words.
    // Word 0 is the most significant.
    typedef union packed {
        logic [NB_DATA-1:0] elem;
        logic [0:NB_WORDS-1][NB_AXI_DATA-1:0] words;
    } ghash_block_u;

    // One-cycle command pulses toward the engine.
    // Clear sits at bit 1 and absorb at bit 0, as in the control word.
    typedef struct packed {
        logic clear;
        logic absorb;
    } ghash_cmd_t;

endpackage

/* design/axil_ghash_regs.sv */
// AXI4-Lite register block for the GHASH engine: key, data, control, state and count.
`timescale 1ns/1ps

module axil_ghash_regs
    import ghash_pkg::*;
(
    input  logic                   i_clock,
    input  logic                   i_rst,
    // Write address and data.
    input  logic                   i_awvalid,
    input  logic [NB_AXI_ADDR-1:0] i_awaddr,
    input  logic                   i_wvalid,
    input  logic [NB_AXI_DATA-1:0] i_wdata,
    input  logic [NB_AXI_STRB-1:0] i_wstrb,
    // Write response.
    input  logic                   i_bready,
    output logic                   o_awready,
    output logic                   o_wready,
    output logic                   o_bvalid,
    output logic [NB_RESP-1:0]     o_bresp,
    // Read address and data.
    input  logic                   i_arvalid,
    input  logic [NB_AXI_ADDR-1:0] i_araddr,
    input  logic                   i_rready,
    output logic                   o_arready,
    output logic                   o_rvalid,
    output logic [NB_AXI_DATA-1:0] o_rdata,
    output logic [NB_RESP-1:0]     o_rresp,
    // Engine side.
    input  ghash_block_u           i_y_state,
    input  logic [NB_COUNT-1:0]    i_count,
    output ghash_cmd_t             o_cmd,
    output ghash_block_u           o_h_key,
    output ghash_block_u           o_x_data
);

    // Handshakes.
    logic                   wr_hs;
    logic                   rd_hs;
    // Write decode.
    logic                   wr_is_h;
    logic                   wr_is_x;
    logic                   wr_is_ctrl;
    logic [1:0]             wr_word;
    // Read decode.
    logic [1:0]             rd_word;
    logic [NB_AXI_DATA-1:0] rd_data;
    logic [NB_RESP-1:0]     rd_resp;

    // AW and W are taken together.
    assign wr_hs = o_awready && i_awvalid && i_wvalid;
    assign o_wready = o_awready;

    // Block regions by upper nibble, word by bits 3:2.
    assign wr_is_h = i_awaddr[NB_AXI_ADDR-1:4] == ADDR_H0[NB_AXI_ADDR-1:4];
    assign wr_is_x = i_awaddr[NB_AXI_ADDR-1:4] == ADDR_X0[NB_AXI_ADDR-1:4];
    assign wr_is_ctrl = i_awaddr[NB_AXI_ADDR-1:2] == ADDR_CTRL[NB_AXI_ADDR-1:2];
    assign wr_word = i_awaddr[3:2];

    // Ready pulses for one cycle, never while B is pending.
    always_ff @(posedge i_clock)
    begin : l_wr_chan
        if (i_rst)
        begin
            o_awready <= 1'b0;
            o_bvalid <= 1'b0;
        end
        else
        begin
            o_awready <= !o_awready && !o_bvalid && i_awvalid && i_wvalid;
            if (wr_hs)
            begin
                o_bvalid <= 1'b1;
            end
            else if (i_bready)
            begin
                o_bvalid <= 1'b0;
            end
        end
    end

    // Only H, X and control accept writes.
    always_ff @(posedge i_clock)
    begin : l_bresp
        if (wr_hs)
        begin
            o_bresp <= (wr_is_h || wr_is_x || wr_is_ctrl) ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // Key and data words, byte strobes honored.
    always_ff @(posedge i_clock)
    begin : l_key_data
        if (i_rst)
        begin
            o_h_key.elem <= '0;
            o_x_data.elem <= '0;
        end
        else if (wr_hs)
        begin
            for (int b = 0; b < NB_AXI_STRB; b++)
            begin
                if (wr_is_h && i_wstrb[b])
                begin
                    o_h_key.words[wr_word][b*NB_BYTE +: NB_BYTE] <=
                        i_wdata[b*NB_BYTE +: NB_BYTE];
                end
                if (wr_is_x && i_wstrb[b])
                begin
                    o_x_data.words[wr_word][b*NB_BYTE +: NB_BYTE] <=
                        i_wdata[b*NB_BYTE +: NB_BYTE];
                end
            end
        end
    end

    // Control write becomes a single-cycle pulse.
    always_ff @(posedge i_clock)
    begin : l_cmd
        if (i_rst)
        begin
            o_cmd <= '0;
        end
        else
        begin
            o_cmd <= '0;
            if (wr_hs && wr_is_ctrl)
            begin
                o_cmd.absorb <= i_wdata[CTRL_ABSORB];
                o_cmd.clear <= i_wdata[CTRL_CLEAR];
            end
        end
    end

    // AR accepted whenever no R is pending.
    assign o_arready = !o_rvalid;
    assign rd_hs = o_arready && i_arvalid;
    assign rd_word = i_araddr[3:2];

    // Read mux. Control is write-only and reads like an unmapped slot.
    always_comb
    begin : l_rd_mux
        rd_data = '0;
        rd_resp = RESP_OKAY;
        if (i_araddr[NB_AXI_ADDR-1:4] == ADDR_H0[NB_AXI_ADDR-1:4])
        begin
            rd_data = o_h_key.words[rd_word];
        end
        else if (i_araddr[NB_AXI_ADDR-1:4] == ADDR_X0[NB_AXI_ADDR-1:4])
        begin
            rd_data = o_x_data.words[rd_word];
        end
        else if (i_araddr[NB_AXI_ADDR-1:4] == ADDR_Y0[NB_AXI_ADDR-1:4])
        begin
            rd_data = i_y_state.words[rd_word];
        end
        else if (i_araddr[NB_AXI_ADDR-1:2] == ADDR_COUNT[NB_AXI_ADDR-1:2])
        begin
            rd_data = NB_AXI_DATA'(i_count);
        end
        else
        begin
            rd_resp = RESP_SLVERR;
        end
    end

    // R valid until the host takes it.
    always_ff @(posedge i_clock)
    begin : l_rd_chan
        if (i_rst)
        begin
            o_rvalid <= 1'b0;
        end
        else if (rd_hs)
        begin
            o_rvalid <= 1'b1;
        end
        else if (i_rready)
        begin
            o_rvalid <= 1'b0;
        end
    end

    // Read payload captured at the AR handshake.
    always_ff @(posedge i_clock)
    begin : l_rd_data
        if (rd_hs)
        begin
            o_rdata <= rd_data;
            o_rresp <= rd_resp;
        end
    end

    // B held until accepted.
    a_bvalid_hold : assert property (@(posedge i_clock) disable iff (i_rst)
        o_bvalid && !i_bready |=> o_bvalid && $stable(o_bresp));

    // R and its data held until accepted.
    a_rvalid_hold : assert property (@(posedge i_clock) disable iff (i_rst)
        o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata));

endmodule

/* design/ghash_top.sv */
// GHASH accelerator top: AXI4-Lite register block wired to the GHASH engine.
`timescale 1ns/1ps

module ghash_top
    import ghash_pkg::*;
(
    input  logic                   i_clock,
    input  logic                   i_rst,
    input  logic                   i_awvalid,
    input  logic [NB_AXI_ADDR-1:0] i_awaddr,
    input  logic                   i_wvalid,
    input  logic [NB_AXI_DATA-1:0] i_wdata,
    input  logic [NB_AXI_STRB-1:0] i_wstrb,
    input  logic                   i_bready,
    output logic                   o_awready,
    output logic                   o_wready,
    output logic                   o_bvalid,
    output logic [NB_RESP-1:0]     o_bresp,
    input  logic                   i_arvalid,
    input  logic [NB_AXI_ADDR-1:0] i_araddr,
    input  logic                   i_rready,
    output logic                   o_arready,
    output logic                   o_rvalid,
    output logic [NB_AXI_DATA-1:0] o_rdata,
    output logic [NB_RESP-1:0]     o_rresp
);

    // Register block to engine.
    ghash_cmd_t          cmd;
    ghash_block_u        h_key;
    ghash_block_u        x_data;
    // Engine back to register block.
    ghash_block_u        y_state;
    logic [NB_COUNT-1:0] count;

    axil_ghash_regs u_axil_ghash_regs
    (
        .i_clock   (i_clock),
        .i_rst     (i_rst),
        .i_awvalid (i_awvalid),
        .i_awaddr  (i_awaddr),
        .i_wvalid  (i_wvalid),
        .i_wdata   (i_wdata),
        .i_wstrb   (i_wstrb),
        .i_bready  (i_bready),
        .o_awready (o_awready),
        .o_wready  (o_wready),
        .o_bvalid  (o_bvalid),
        .o_bresp   (o_bresp),
        .i_arvalid (i_arvalid),
        .i_araddr  (i_araddr),
        .i_rready  (i_rready),
        .o_arready (o_arready),
        .o_rvalid  (o_rvalid),
        .o_rdata   (o_rdata),
        .o_rresp   (o_rresp),
        .i_y_state (y_state),
        .i_count   (count),
        .o_cmd     (cmd),
        .o_h_key   (h_key),
        .o_x_data  (x_data)
    );

    ghash_engine u_ghash_engine
    (
        .i_clock   (i_clock),
        .i_rst     (i_rst),
        .i_cmd     (cmd),
        .i_h_key   (h_key),
        .i_x_data  (x_data),
        .o_y_state (y_state),
        .o_count   (count)
    );

endmodule

/* dv/tb_ghash.sv */
// GHASH accelerator testbench: AXI4-Lite host, reference GHASH model and checks.
`timescale 1ns/1ps

module tb_ghash
    import ghash_pkg::*;
;

    // About four times the expected run of roughly 11000 cycles.
    localparam int TIMEOUT_CYCLES = 48000;
    localparam int NUM_CHAINS = 50;

    logic                   i_clock;
    logic                   i_rst;
    logic                   i_awvalid;
    logic [NB_AXI_ADDR-1:0] i_awaddr;
    logic                   i_wvalid;
    logic [NB_AXI_DATA-1:0] i_wdata;
    logic [NB_AXI_STRB-1:0] i_wstrb;
    logic                   i_bready;
    logic                   o_awready;
    logic                   o_wready;
    logic                   o_bvalid;
    logic [NB_RESP-1:0]     o_bresp;
    logic                   i_arvalid;
    logic [NB_AXI_ADDR-1:0] i_araddr;
    logic                   i_rready;
    logic                   o_arready;
    logic                   o_rvalid;
    logic [NB_AXI_DATA-1:0] o_rdata;
    logic [NB_RESP-1:0]     o_rresp;

    // Expected accelerator state.
    ghash_block_u        model_h;
    ghash_block_u        model_x;
    ghash_block_u        model_y;
    logic [NB_COUNT-1:0] model_count;
    int                  cycle_count;

    ghash_top u_ghash_top
    (
        .i_clock   (i_clock),
        .i_rst     (i_rst),
        .i_awvalid (i_awvalid),
        .i_awaddr  (i_awaddr),
        .i_wvalid  (i_wvalid),
        .i_wdata   (i_wdata),
        .i_wstrb   (i_wstrb),
        .i_bready  (i_bready),
        .o_awready (o_awready),
        .o_wready  (o_wready),
        .o_bvalid  (o_bvalid),
        .o_bresp   (o_bresp),
        .i_arvalid (i_arvalid),
        .i_araddr  (i_araddr),
        .i_rready  (i_rready),
        .o_arready (o_arready),
        .o_rvalid  (o_rvalid),
        .o_rdata   (o_rdata),
        .o_rresp   (o_rresp)
    );

    // 100 ns clock.
    initial
    begin
        i_clock = 1'b0;
    end

    always #50 i_clock = ~i_clock;

    // Run limit.
    always @(posedge i_clock)
    begin : l_timeout
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles, the tests did not finish", cycle_count);
            $display("Test failures found");
            $fatal(1, "simulation stopped on timeout");
        end
    end

    // GCM field product, MSB-first bit walk.
    // V is halved each step and 0xE1 folds into the top byte on carry out.
    function automatic logic [NB_DATA-1:0] ref_gf_mult(input logic [NB_DATA-1:0] a,
                                                        input logic [NB_DATA-1:0] b);
        logic [NB_DATA-1:0] z;
        logic [NB_DATA-1:0] v;
        logic               carry;
        z = '0;
        v = b;
        for (int j = 0; j < NB_DATA; j++)
        begin
            if (a[NB_DATA-1-j])
            begin
                z = z ^ v;
            end
            carry = v[0];
            v = v >> 1;
            if (carry)
            begin
                v[NB_DATA-1 -: 8] = v[NB_DATA-1 -: 8] ^ 8'he1;
            end
        end
        return z;
    endfunction

    // Bit mask of the enabled bytes.
    function automatic logic [NB_AXI_DATA-1:0] strobe_mask(input logic [NB_AXI_STRB-1:0] strb);
        logic [NB_AXI_DATA-1:0] m;
        for (int b = 0; b < NB_AXI_STRB; b++)
        begin
            m[b*NB_BYTE +: NB_BYTE] = {NB_BYTE{strb[b]}};
        end
        return m;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("mismatch at %0t ns: %s", $time, msg);
        $display("Test failures found");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_block(input ghash_block_u got, input ghash_block_u exp,
                               input string msg);
        if (got !== exp)
        begin
            report_mismatch($sformatf("%s got %h expected %h", msg, got.elem, exp.elem));
        end
    endtask

    task automatic check_count(input logic [NB_COUNT-1:0] got, input logic [NB_COUNT-1:0] exp,
                               input string msg);
        if (got !== exp)
        begin
            report_mismatch($sformatf("%s got %0d expected %0d", msg, got, exp));
        end
    endtask

    task automatic check_resp(input logic [NB_RESP-1:0] got, input logic [NB_RESP-1:0] exp,
                              input string msg);
        if (got !== exp)
        begin
            report_mismatch($sformatf("%s got resp %b expected %b", msg, got, exp));
        end
    endtask

    task automatic check_word(input logic [NB_AXI_DATA-1:0] got,
                              input logic [NB_AXI_DATA-1:0] exp, input string msg);
        if (got !== exp)
        begin
            report_mismatch($sformatf("%s got %h expected %h", msg, got, exp));
        end
    endtask

    // Single write: AW and W together, then B after a random stall.
    task automatic axil_write(input logic [NB_AXI_ADDR-1:0] addr,
                              input logic [NB_AXI_DATA-1:0] data,
                              input logic [NB_AXI_STRB-1:0] strb,
                              output logic [NB_RESP-1:0] resp);
        int unsigned stall;
        i_awvalid = 1'b1;
        i_wvalid = 1'b1;
        i_awaddr = addr;
        i_wdata = data;
        i_wstrb = strb;
        @(negedge i_clock);
        while (!(o_awready && o_wready))
        begin
            @(negedge i_clock);
        end
        @(posedge i_clock);
        #1;
        i_awvalid = 1'b0;
        i_wvalid = 1'b0;
        stall = $urandom_range(3, 0);
        repeat (stall)
        begin
            @(posedge i_clock);
            #1;
        end
        i_bready = 1'b1;
        @(negedge i_clock);
        while (!o_bvalid)
        begin
            @(negedge i_clock);
        end
        resp = o_bresp;
        @(posedge i_clock);
        #1;
        i_bready = 1'b0;
    endtask

    // Single read: AR, then R after a random stall.
    task automatic axil_read(input logic [NB_AXI_ADDR-1:0] addr,
                             output logic [NB_AXI_DATA-1:0] data,
                             output logic [NB_RESP-1:0] resp);
        int unsigned stall;
        i_arvalid = 1'b1;
        i_araddr = addr;
        @(negedge i_clock);
        while (!o_arready)
        begin
            @(negedge i_clock);
        end
        @(posedge i_clock);
        #1;
        i_arvalid = 1'b0;
        stall = $urandom_range(3, 0);
        repeat (stall)
        begin
            @(posedge i_clock);
            #1;
        end
        i_rready = 1'b1;
        @(negedge i_clock);
        while (!o_rvalid)
        begin
            @(negedge i_clock);
        end
        data = o_rdata;
        resp = o_rresp;
        @(posedge i_clock);
        #1;
        i_rready = 1'b0;
    endtask

    task automatic write_block(input logic [NB_AXI_ADDR-1:0] base, input ghash_block_u blk);
        logic [NB_RESP-1:0] resp;
        for (int w = 0; w < NB_WORDS; w++)
        begin
            axil_write(base + NB_AXI_ADDR'(4 * w), blk.words[w], '1, resp);
            check_resp(resp, RESP_OKAY, "block word write");
        end
    endtask

    task automatic read_block(input logic [NB_AXI_ADDR-1:0] base, output ghash_block_u blk);
        logic [NB_RESP-1:0] resp;
        logic [NB_AXI_DATA-1:0] word;
        for (int w = 0; w < NB_WORDS; w++)
        begin
            axil_read(base + NB_AXI_ADDR'(4 * w), word, resp);
            check_resp(resp, RESP_OKAY, "block word read");
            blk.words[w] = word;
        end
    endtask

    // Control write. Clear goes before absorb in the model.
    task automatic send_ctrl(input logic [1:0] bits);
        logic [NB_RESP-1:0] resp;
        axil_write(ADDR_CTRL, NB_AXI_DATA'(bits), '1, resp);
        check_resp(resp, RESP_OKAY, "control write");
        if (bits[CTRL_CLEAR])
        begin
            model_y.elem = '0;
            model_count = '0;
        end
        if (bits[CTRL_ABSORB])
        begin
            model_y.elem = ref_gf_mult(model_y.elem ^ model_x.elem, model_h.elem);
            model_count = model_count + NB_COUNT'(1);
        end
    endtask

    // Y and the count against the model.
    task automatic check_state(input string msg);
        ghash_block_u           y_rd;
        logic [NB_AXI_DATA-1:0] word;
        logic [NB_RESP-1:0]     resp;
        read_block(ADDR_Y0, y_rd);
        check_block(y_rd, model_y, {msg, " state"});
        axil_read(ADDR_COUNT, word, resp);
        check_resp(resp, RESP_OKAY, {msg, " count read"});
        check_count(word[NB_COUNT-1:0], model_count, {msg, " count"});
        check_count(word[NB_AXI_DATA-1:NB_COUNT], '0, {msg, " count upper bits"});
    endtask

    initial
    begin : l_stimulus
        ghash_block_u           blk;
        logic [NB_AXI_DATA-1:0] word;
        logic [NB_AXI_DATA-1:0] mask;
        logic [NB_RESP-1:0]     resp;
        int unsigned            n_blocks;
        void'($urandom(41898));
        i_rst = 1'b1;
        i_awvalid = 1'b0;
        i_awaddr = '0;
        i_wvalid = 1'b0;
        i_wdata = '0;
        i_wstrb = '0;
        i_bready = 1'b0;
        i_arvalid = 1'b0;
        i_araddr = '0;
        i_rready = 1'b0;
        cycle_count = 0;
        model_h.elem = '0;
        model_x.elem = '0;
        model_y.elem = '0;
        model_count = '0;
        repeat (5)
        begin
            @(posedge i_clock);
        end
        #1;
        i_rst = 1'b0;

        // Reset values.
        check_state("after reset");
        read_block(ADDR_H0, blk);
        check_block(blk, model_h, "key after reset");
        read_block(ADDR_X0, blk);
        check_block(blk, model_x, "data after reset");

        // Known-answer chain.
        model_h.elem = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;
        write_block(ADDR_H0, model_h);
        model_x.elem = '0;
        write_block(ADDR_X0, model_x);
        send_ctrl(2'b01);
        check_state("zero block");
        model_x.elem = 128'h0388dace60b6a392f328c2b971b2fe78;
        write_block(ADDR_X0, model_x);
        send_ctrl(2'b01);
        check_state("known block");

        // Random chains, each from a clear.
        for (int k = 0; k < NUM_CHAINS; k++)
        begin
            model_h.elem = {$urandom, $urandom, $urandom, $urandom};
            write_block(ADDR_H0, model_h);
            send_ctrl(2'b10);
            check_state($sformatf("chain %0d clear", k));
            n_blocks = $urandom_range(8, 1);
            for (int b = 0; b < int'(n_blocks); b++)
            begin
                model_x.elem = {$urandom, $urandom, $urandom, $urandom};
                write_block(ADDR_X0, model_x);
                send_ctrl(2'b01);
                check_state($sformatf("chain %0d block %0d", k, b));
            end
        end

        // Clear and absorb in one write.
        model_x.elem = {$urandom, $urandom, $urandom, $urandom};
        write_block(ADDR_X0, model_x);
        send_ctrl(2'b11);
        check_state("combined clear and absorb");

        // Partial strobes on H word 1 and X word 3.
        word = $urandom;
        mask = strobe_mask(4'b0101);
        axil_write(ADDR_H0 + 8'h04, word, 4'b0101, resp);
        check_resp(resp, RESP_OKAY, "partial key write");
        model_h.words[1] = (model_h.words[1] & ~mask) | (word & mask);
        read_block(ADDR_H0, blk);
        check_block(blk, model_h, "partial key readback");
        word = $urandom;
        mask = strobe_mask(4'b1010);
        axil_write(ADDR_X0 + 8'h0c, word, 4'b1010, resp);
        check_resp(resp, RESP_OKAY, "partial data write");
        model_x.words[3] = (model_x.words[3] & ~mask) | (word & mask);
        read_block(ADDR_X0, blk);
        check_block(blk, model_x, "partial data readback");
        send_ctrl(2'b01);
        check_state("absorb after partial writes");

        // Error responses leave the state alone.
        axil_read(8'h50, word, resp);
        check_resp(resp, RESP_SLVERR, "unmapped read");
        check_word(word, '0, "unmapped read data");
        axil_read(ADDR_CTRL, word, resp);
        check_resp(resp, RESP_SLVERR, "control read");
        axil_write(ADDR_Y0, 32'hffffffff, '1, resp);
        check_resp(resp, RESP_SLVERR, "state write");
        axil_write(ADDR_COUNT, 32'h00000003, '1, resp);
        check_resp(resp, RESP_SLVERR, "count write");
        axil_write(8'h60, 32'h00000003, '1, resp);
        check_resp(resp, RESP_SLVERR, "unmapped write");
        check_state("after error accesses");
        read_block(ADDR_H0, blk);
        check_block(blk, model_h, "key after error accesses");
        read_block(ADDR_X0, blk);
        check_block(blk, model_x, "data after error accesses");

        $display("All tests passed!");
        $finish;
    end

endmodule

/* ghash/gf_2to128_multiplier.sv */
// Combinational GF(2^128) multiplier in GCM bit order, shift-and-reduce form.
`timescale 1ns/1ps

module gf_2to128_multiplier
    import ghash_pkg::*;
(
    input  logic [NB_DATA-1:0] i_data_x,
    input  logic [NB_DATA-1:0] i_data_y,
    output logic [NB_DATA-1:0] o_data_z
);

    // Running product.
    logic [NB_DATA-1:0] acc_z;
    // Multiplicand, times x after each step.
    logic [NB_DATA-1:0] shift_v;

    // Walk X from its first bit, which is bit 127.
    // Each set bit accumulates the current power of Y.
    always_comb
    begin : l_mult
        acc_z = '0;
        shift_v = i_data_y;
        for (int i = NB_DATA - 1; i >= 0; i--)
        begin
            // Accumulate when this bit of X is set.
            if (i_data_x[i])
            begin
                acc_z = acc_z ^ shift_v;
            end
            // Multiply V by x.
            // Right shift in GCM order; the bit shifted out is the x^127 term.
            if (shift_v[0])
            begin
                // Overflow past x^127 folds back through 0xE1.
                shift_v = (shift_v >> 1) ^ GF_R;
            end
            else
            begin
                shift_v = shift_v >> 1;
            end
        end
    end

    // Product out, no clock in this block.
    assign o_data_z = acc_z;

endmodule

/* ghash/ghash_core.sv */
// GHASH block step: folds a block into the previous state and multiplies by H.
`timescale 1ns/1ps

module ghash_core
    import ghash_pkg::*;
(
    input  logic         i_clock,
    input  logic         i_rst,
    input  logic         i_valid,
    input  ghash_block_u i_data_x,
    input  ghash_block_u i_data_x_prev,
    input  ghash_block_u i_h_key,
    output logic         o_valid,
    output ghash_block_u o_data_y
);

    // Block XOR state.
    logic [NB_DATA-1:0] x_xor;
    // Raw product from the multiplier.
    logic [NB_DATA-1:0] data_y;

    assign x_xor = i_data_x.elem ^ i_data_x_prev.elem;

    // Full product in one cycle.
    gf_2to128_multiplier u_gf_2to128_multiplier
    (
        .i_data_x (x_xor),
        .i_data_y (i_h_key.elem),
        .o_data_z (data_y)
    );

    // Product register, loaded only on a valid step.
    always_ff @(posedge i_clock)
    begin : l_reg_out
        if (i_valid)
        begin
            o_data_y.elem <= data_y;
        end
    end

    // Valid strobe, one cycle behind the input.
    always_ff @(posedge i_clock)
    begin : l_reg_valid
        if (i_rst)
        begin
            o_valid <= 1'b0;
        end
        else
        begin
            o_valid <= i_valid;
        end
    end

    // Bus handshakes keep absorb commands at least two cycles apart.
    a_single_valid : assert property (@(posedge i_clock) disable iff (i_rst)
        o_valid |=> !o_valid);

endmodule

/* ghash/ghash_engine.sv */
// GHASH engine: running state Y, absorbed-block count and command sequencing.
`timescale 1ns/1ps

module ghash_engine
    import ghash_pkg::*;
(
    input  logic                i_clock,
    input  logic                i_rst,
    input  ghash_cmd_t          i_cmd,
    input  ghash_block_u        i_h_key,
    input  ghash_block_u        i_x_data,
    output ghash_block_u        o_y_state,
    output logic [NB_COUNT-1:0] o_count
);

    // Stored state and count.
    ghash_block_u        y_q;
    logic [NB_COUNT-1:0] count_q;
    // Previous state into the core.
    ghash_block_u        x_prev;
    // Core result.
    logic                core_valid;
    ghash_block_u        core_y;

    // Combined clear and absorb starts from a zero state.
    assign x_prev.elem = i_cmd.clear ? '0 : y_q.elem;

    ghash_core u_ghash_core
    (
        .i_clock       (i_clock),
        .i_rst         (i_rst),
        .i_valid       (i_cmd.absorb),
        .i_data_x      (i_x_data),
        .i_data_x_prev (x_prev),
        .i_h_key       (i_h_key),
        .o_valid       (core_valid),
        .o_data_y      (core_y)
    );

    // Core result loads Y and bumps the count.
    // Clear zeroes both in the command cycle.
    always_ff @(posedge i_clock)
    begin : l_state
        if (i_rst)
        begin
            y_q.elem <= '0;
            count_q <= '0;
        end
        else if (core_valid)
        begin
            y_q <= core_y;
            count_q <= count_q + NB_COUNT'(1);
        end
        else if (i_cmd.clear)
        begin
            y_q.elem <= '0;
            count_q <= '0;
        end
    end

    // Forward the fresh product so it is readable two cycles after the write.
    // Count wraps like the stored one.
    assign o_y_state.elem = core_valid ? core_y.elem : y_q.elem;
    assign o_count = count_q + NB_COUNT'(core_valid);

endmodule

/* tb.f */
common/ghash_pkg.sv
ghash/gf_2to128_multiplier.sv
ghash/ghash_core.sv
ghash/ghash_engine.sv
design/axil_ghash_regs.sv
design/ghash_top.sv
dv/tb_ghash.sv
